/* vga_pkg.sv */
package vga_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Counter width, enough for 1056 clocks per line
  localparam int CNT_W = 11;
  // 4 bits each of red, green, blue
  localparam int RGB_W = 12;

  //////////////////////////////////////////////////
  // SVGA 800x600 at 60 Hz, 40 MHz pixel clock
  //////////////////////////////////////////////////

  // Horizontal, in pixel clocks
  localparam logic [CNT_W-1:0] H_ACTIVE     = 11'd800;
  localparam logic [CNT_W-1:0] H_TOTAL      = 11'd1056;
  localparam logic [CNT_W-1:0] H_SYNC_START = 11'd840;
  // First clock after the pulse
  localparam logic [CNT_W-1:0] H_SYNC_END   = 11'd968;

  // Vertical, in lines
  localparam logic [CNT_W-1:0] V_ACTIVE     = 11'd600;
  localparam logic [CNT_W-1:0] V_TOTAL      = 11'd628;
  localparam logic [CNT_W-1:0] V_SYNC_START = 11'd601;
  localparam logic [CNT_W-1:0] V_SYNC_END   = 11'd605;

  //////////////////////////////////////////////////
  // Colors, 12'hRGB
  //////////////////////////////////////////////////

  localparam logic [RGB_W-1:0] COL_BLACK  = 12'h0_0_0;
  localparam logic [RGB_W-1:0] COL_TOP    = 12'hf_f_0;  // yellow
  localparam logic [RGB_W-1:0] COL_BOTTOM = 12'hf_0_0;  // red
  localparam logic [RGB_W-1:0] COL_LEFT   = 12'h0_f_0;  // green
  localparam logic [RGB_W-1:0] COL_RIGHT  = 12'h0_0_f;  // blue
  localparam logic [RGB_W-1:0] COL_FILL   = 12'h8_8_8;  // gray
  localparam logic [RGB_W-1:0] COL_RECT   = 12'ha_3_c;  // purple

  // Overlay rectangle size
  localparam logic [CNT_W-1:0] RECT_W = 11'd64;
  localparam logic [CNT_W-1:0] RECT_H = 11'd48;

endpackage

/* vga_timing.sv */
`timescale 1ns/1ps

module vga_timing import vga_pkg::*; (
  input  logic             pclk,
  input  logic             rst,

  output logic [CNT_W-1:0] vcount,
  output logic             vsync,
  output logic             vblnk,
  output logic [CNT_W-1:0] hcount,
  output logic             hsync,
  output logic             hblnk
);

  //////////////////////////////////////////////////
  // Next-value logic
  //////////////////////////////////////////////////

  logic [CNT_W-1:0] hcount_nxt;
  logic [CNT_W-1:0] vcount_nxt;
  logic             hsync_nxt;
  logic             hblnk_nxt;
  logic             vsync_nxt;
  logic             vblnk_nxt;
  logic             h_wrap;
  logic             v_wrap;

  // Last clock of the line / last line of the frame
  assign h_wrap = (hcount == H_TOTAL - 11'd1);
  assign v_wrap = (vcount == V_TOTAL - 11'd1);

  always_comb begin
    // Horizontal counter, wraps every line
    if (h_wrap) begin
      hcount_nxt = '0;
    end else begin
      hcount_nxt = hcount + 11'd1;
    end

    // Vertical counter only moves at end of line
    if (h_wrap) begin
      if (v_wrap) begin
        vcount_nxt = '0;
      end else begin
        vcount_nxt = vcount + 11'd1;
      end
    end else begin
      vcount_nxt = vcount;
    end
  end

  // Flags decoded from next counts
  // so they land in the same cycle as the counts
  always_comb begin
    hblnk_nxt = (hcount_nxt >= H_ACTIVE);
    hsync_nxt = (hcount_nxt >= H_SYNC_START) && (hcount_nxt < H_SYNC_END);
    vblnk_nxt = (vcount_nxt >= V_ACTIVE);
    vsync_nxt = (vcount_nxt >= V_SYNC_START) && (vcount_nxt < V_SYNC_END);
  end

  //////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////

  // Reset state (0,0) already decodes to sync and blank low,
  // so first cycle out of reset is a valid pixel
  always_ff @(posedge pclk) begin
    if (rst) begin
      hcount <= '0;
      vcount <= '0;
      hsync  <= 1'b0;
      hblnk  <= 1'b0;
      vsync  <= 1'b0;
      vblnk  <= 1'b0;
    end else begin
      hcount <= hcount_nxt;
      vcount <= vcount_nxt;
      hsync  <= hsync_nxt;
      hblnk  <= hblnk_nxt;
      vsync  <= vsync_nxt;
      vblnk  <= vblnk_nxt;
    end
  end

endmodule

/* draw_background.sv */
`timescale 1ns/1ps

module draw_background import vga_pkg::*; (
  input  logic             pclk,
  input  logic             rst,

  input  logic [CNT_W-1:0] vcount_in,
  input  logic             vsync_in,
  input  logic             vblnk_in,
  input  logic [CNT_W-1:0] hcount_in,
  input  logic             hsync_in,
  input  logic             hblnk_in,

  output logic [CNT_W-1:0] vcount_out,
  output logic             vsync_out,
  output logic             vblnk_out,
  output logic [CNT_W-1:0] hcount_out,
  output logic             hsync_out,
  output logic             hblnk_out,
  output logic [RGB_W-1:0] rgb_out
);

  logic [RGB_W-1:0] rgb_nxt;

  //////////////////////////////////////////////////
  // Border rule, first match wins
  //////////////////////////////////////////////////

  always_comb begin
    if (vblnk_in || hblnk_in) begin
      // Nothing visible in blanking
      rgb_nxt = COL_BLACK;
    end else if (vcount_in == '0) begin
      // Top and bottom lines take the corners
      rgb_nxt = COL_TOP;
    end else if (vcount_in == V_ACTIVE - 11'd1) begin
      rgb_nxt = COL_BOTTOM;
    end else if (hcount_in == '0) begin
      rgb_nxt = COL_LEFT;
    end else if (hcount_in == H_ACTIVE - 11'd1) begin
      rgb_nxt = COL_RIGHT;
    end else begin
      // Interior
      rgb_nxt = COL_FILL;
    end
  end

  // One stage, timing and color stay aligned
  always_ff @(posedge pclk) begin
    if (rst) begin
      vcount_out <= '0;
      vsync_out  <= 1'b0;
      vblnk_out  <= 1'b0;
      hcount_out <= '0;
      hsync_out  <= 1'b0;
      hblnk_out  <= 1'b0;
      rgb_out    <= '0;
    end else begin
      vcount_out <= vcount_in;
      vsync_out  <= vsync_in;
      vblnk_out  <= vblnk_in;
      hcount_out <= hcount_in;
      hsync_out  <= hsync_in;
      hblnk_out  <= hblnk_in;
      rgb_out    <= rgb_nxt;
    end
  end

endmodule

/* draw_rect.sv */
`timescale 1ns/1ps

module draw_rect import vga_pkg::*; (
  input  logic             pclk,
  input  logic             rst,

  input  logic [CNT_W-1:0] vcount_in,
  input  logic             vsync_in,
  input  logic             vblnk_in,
  input  logic [CNT_W-1:0] hcount_in,
  input  logic             hsync_in,
  input  logic             hblnk_in,
  input  logic [RGB_W-1:0] rgb_in,

  // Top-left corner, may change at any time
  input  logic [CNT_W-1:0] xpos,
  input  logic [CNT_W-1:0] ypos,

  output logic [CNT_W-1:0] vcount_out,
  output logic             vsync_out,
  output logic             vblnk_out,
  output logic [CNT_W-1:0] hcount_out,
  output logic             hsync_out,
  output logic             hblnk_out,
  output logic [RGB_W-1:0] rgb_out
);

  logic             vblnk_prev;
  logic             vblnk_rise;
  logic [CNT_W-1:0] x_hold;
  logic [CNT_W-1:0] y_hold;
  logic             in_rect;
  logic [RGB_W-1:0] rgb_nxt;

  //////////////////////////////////////////////////
  // Per-frame position capture
  //////////////////////////////////////////////////

  // First cycle of vertical blanking
  assign vblnk_rise = vblnk_in && !vblnk_prev;

  always_ff @(posedge pclk) begin
    if (rst) begin
      vblnk_prev <= 1'b0;
      x_hold     <= '0;
      y_hold     <= '0;
    end else begin
      vblnk_prev <= vblnk_in;
      // Held for the whole next frame, no tearing
      if (vblnk_rise) begin
        x_hold <= xpos;
        y_hold <= ypos;
      end
    end
  end

  //////////////////////////////////////////////////
  // Window compare and overlay
  //////////////////////////////////////////////////

  // Max 799 + 64 fits in 11 bits, no overflow
  // Right and bottom clip falls out of the blanking test
  assign in_rect = (hcount_in >= x_hold) && (hcount_in < x_hold + RECT_W) &&
                   (vcount_in >= y_hold) && (vcount_in < y_hold + RECT_H);

  assign rgb_nxt = (!vblnk_in && !hblnk_in && in_rect) ? COL_RECT : rgb_in;

  always_ff @(posedge pclk) begin
    if (rst) begin
      vcount_out <= '0;
      vsync_out  <= 1'b0;
      vblnk_out  <= 1'b0;
      hcount_out <= '0;
      hsync_out  <= 1'b0;
      hblnk_out  <= 1'b0;
      rgb_out    <= '0;
    end else begin
      vcount_out <= vcount_in;
      vsync_out  <= vsync_in;
      vblnk_out  <= vblnk_in;
      hcount_out <= hcount_in;
      hsync_out  <= hsync_in;
      hblnk_out  <= hblnk_in;
      rgb_out    <= rgb_nxt;
    end
  end

endmodule

/* vga_top.sv */
`timescale 1ns/1ps

module vga_top import vga_pkg::*; (
  input  logic             pclk,
  input  logic             rst,
  input  logic [CNT_W-1:0] xpos,
  input  logic [CNT_W-1:0] ypos,
  output logic             vs,
  output logic             hs,
  output logic [3:0]       r,
  output logic [3:0]       g,
  output logic [3:0]       b
);

  //////////////////////////////////////////////////
  // Stage links
  //////////////////////////////////////////////////

  // Timing generator out
  logic [CNT_W-1:0] vcount_t, hcount_t;
  logic             vsync_t, vblnk_t, hsync_t, hblnk_t;

  // Background out
  logic [CNT_W-1:0] vcount_b, hcount_b;
  logic             vsync_b, vblnk_b, hsync_b, hblnk_b;
  logic [RGB_W-1:0] rgb_b;

  // Rectangle out, last stage
  logic [RGB_W-1:0] rgb_r;

  vga_timing u_vga_timing (
    .pclk   (pclk),
    .rst    (rst),
    .vcount (vcount_t),
    .vsync  (vsync_t),
    .vblnk  (vblnk_t),
    .hcount (hcount_t),
    .hsync  (hsync_t),
    .hblnk  (hblnk_t)
  );

  // Stage 1 of 2
  draw_background u_draw_background (
    .pclk       (pclk),
    .rst        (rst),
    .vcount_in  (vcount_t),
    .vsync_in   (vsync_t),
    .vblnk_in   (vblnk_t),
    .hcount_in  (hcount_t),
    .hsync_in   (hsync_t),
    .hblnk_in   (hblnk_t),
    .vcount_out (vcount_b),
    .vsync_out  (vsync_b),
    .vblnk_out  (vblnk_b),
    .hcount_out (hcount_b),
    .hsync_out  (hsync_b),
    .hblnk_out  (hblnk_b),
    .rgb_out    (rgb_b)
  );

  // Stage 2 of 2, counts and blanking not needed past here
  draw_rect u_draw_rect (
    .pclk       (pclk),
    .rst        (rst),
    .vcount_in  (vcount_b),
    .vsync_in   (vsync_b),
    .vblnk_in   (vblnk_b),
    .hcount_in  (hcount_b),
    .hsync_in   (hsync_b),
    .hblnk_in   (hblnk_b),
    .rgb_in     (rgb_b),
    .xpos       (xpos),
    .ypos       (ypos),
    .vcount_out (),
    .vsync_out  (vs),
    .vblnk_out  (),
    .hcount_out (),
    .hsync_out  (hs),
    .hblnk_out  (),
    .rgb_out    (rgb_r)
  );

  // Split 12'hRGB onto pins
  assign r = rgb_r[11:8];
  assign g = rgb_r[7:4];
  assign b = rgb_r[3:0];

endmodule

/* vga_props.sv */
`timescale 1ns/1ps

module vga_props import vga_pkg::*; (
  input logic             pclk,
  input logic             rst,
  input logic [CNT_W-1:0] vcount,
  input logic             vsync,
  input logic             vblnk,
  input logic [CNT_W-1:0] hcount,
  input logic             hsync,
  input logic             hblnk
);

  // Failure tallies, one per property
  int n_hs;
  int n_vs;
  int n_hc;
  int n_vc;
  int fail_cnt;

  assign fail_cnt = n_hs + n_vs + n_hc + n_vc;

  //////////////////////////////////////////////////
  // Sync pulses lie inside blanking
  //////////////////////////////////////////////////

  hsync_in_blank: assert property (@(posedge pclk) disable iff (rst) hsync |-> hblnk)
    else begin
      n_hs++;
      $error("hsync high outside horizontal blanking");
    end

  vsync_in_blank: assert property (@(posedge pclk) disable iff (rst) vsync |-> vblnk)
    else begin
      n_vs++;
      $error("vsync high outside vertical blanking");
    end

  // Counter range
  hcount_range: assert property (@(posedge pclk) disable iff (rst) hcount < H_TOTAL)
    else begin
      n_hc++;
      $error("hcount past end of line");
    end

  // Line counter moves only on the line wrap
  vcount_steady: assert property (@(posedge pclk) disable iff (rst)
                                  (hcount != H_TOTAL - 11'd1) |=> $stable(vcount))
    else begin
      n_vc++;
      $error("vcount changed in mid-line");
    end

endmodule

bind vga_timing vga_props u_vga_props (
  .pclk   (pclk),
  .rst    (rst),
  .vcount (vcount),
  .vsync  (vsync),
  .vblnk  (vblnk),
  .hcount (hcount),
  .hsync  (hsync),
  .hblnk  (hblnk)
);

/* vga_tb.sv */
`timescale 1ns/1ps

module vga_tb import vga_pkg::*; ();

  localparam int FRAME_CYCLES = int'(H_TOTAL) * int'(V_TOTAL);
  // Three frames plus margin
  localparam int RUN_CYCLES   = 3 * FRAME_CYCLES + 2000;
  // Four frames at 8 ns
  localparam int WATCHDOG_NS  = 4 * FRAME_CYCLES * 8;
  localparam int MAX_SHOWN    = 20;

  logic             pclk;
  logic             rst;
  logic [CNT_W-1:0] xpos;
  logic [CNT_W-1:0] ypos;
  logic             vs;
  logic             hs;
  logic [3:0]       r;
  logic [3:0]       g;
  logic [3:0]       b;

  // Model state: timing pixel, background stage output, expected DUT output
  logic [CNT_W-1:0] t_h, t_v, b_h, b_v, x_held, y_held;
  logic             b_hs, b_vs, b_hb, b_vb, vb_prev;
  logic [RGB_W-1:0] b_rgb, e_rgb;
  logic             e_hs, e_vs;
  logic [2:0]       e_tst;
  int               cyc;

  // Tallies indexed by test number 1..5
  int n_chk [8];
  int n_err [8];
  int total_chk;
  int total_err;

  vga_top uut (
    .pclk (pclk),
    .rst  (rst),
    .xpos (xpos),
    .ypos (ypos),
    .vs   (vs),
    .hs   (hs),
    .r    (r),
    .g    (g),
    .b    (b)
  );

  always #4 pclk = ~pclk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check_value(input logic [2:0] tst, input logic [31:0] got,
                             input logic [31:0] exp, input string what);
    n_chk[tst] = n_chk[tst] + 1;
    total_chk = total_chk + 1;
    if (got !== exp) begin
      n_err[tst] = n_err[tst] + 1;
      total_err = total_err + 1;
      if (total_err <= MAX_SHOWN) begin
        $display("[ERROR] %0t: %s mismatch, got %0h expected %0h", $time, what, got, exp);
      end
    end
  endtask

  task automatic report_test(input logic [2:0] tst, input string name);
    $display("test %0d %s: %0d checks, %0d errors", tst, name, n_chk[tst], n_err[tst]);
  endtask

  // Frame border, top and bottom win the corners
  function automatic logic [RGB_W-1:0] border_color(input logic [CNT_W-1:0] h,
                                                    input logic [CNT_W-1:0] v);
    logic [RGB_W-1:0] col;
    if (h >= H_ACTIVE || v >= V_ACTIVE) begin
      col = COL_BLACK;
    end else if (v == '0) begin
      col = COL_TOP;
    end else if (v == V_ACTIVE - 11'd1) begin
      col = COL_BOTTOM;
    end else if (h == '0) begin
      col = COL_LEFT;
    end else if (h == H_ACTIVE - 11'd1) begin
      col = COL_RIGHT;
    end else begin
      col = COL_FILL;
    end
    return col;
  endfunction

  function automatic logic in_window(input logic [CNT_W-1:0] h, v, x, y);
    return (h >= x) && (h < x + RECT_W) && (v >= y) && (v < y + RECT_H);
  endfunction

  //////////////////////////////////////////////////
  // Reference model and compare, mid-cycle
  //////////////////////////////////////////////////

  always @(negedge pclk) begin
    logic in_held;
    logic in_live;
    if ($time != 0) begin
      if (rst) begin
        check_value(3'd1, 32'({vs, hs, r, g, b}), 32'd0, "output in reset");
        // Pipeline cleared, timing restarts at pixel (0,0)
        t_h = '0;
        t_v = '0;
        b_h = '0;
        b_v = '0;
        {b_hs, b_vs, b_hb, b_vb, vb_prev, e_hs, e_vs} = '0;
        b_rgb = '0;
        e_rgb = '0;
        x_held = '0;
        y_held = '0;
        e_tst = 3'd1;
        cyc = 0;
      end else begin
        check_value((cyc < 2) ? 3'd1 : 3'd2, 32'({vs, hs}), 32'({e_vs, e_hs}), "vs/hs");
        check_value(e_tst, 32'({r, g, b}), 32'(e_rgb), "rgb");

        // Rectangle stage on the background bundle of this cycle
        // Cycle 0 bundle is the cleared one, held window at origin covers it
        in_held = !b_vb && !b_hb && in_window(b_h, b_v, x_held, y_held);
        in_live = !b_vb && !b_hb && in_window(b_h, b_v, xpos, ypos);
        if (cyc == 0) begin
          e_tst = 3'd1;
        end else if (in_held != in_live) begin
          // Pending position not yet captured
          e_tst = 3'd5;
        end else begin
          e_tst = in_held ? 3'd4 : 3'd3;
        end
        e_hs = b_hs;
        e_vs = b_vs;
        e_rgb = in_held ? COL_RECT : b_rgb;
        // First line of vertical blanking takes the new position
        if (b_vb && !vb_prev) begin
          x_held = xpos;
          y_held = ypos;
        end
        vb_prev = b_vb;

        // Background stage on the timing pixel
        b_h = t_h;
        b_v = t_v;
        b_hb = (t_h >= H_ACTIVE);
        b_vb = (t_v >= V_ACTIVE);
        b_hs = (t_h >= H_SYNC_START) && (t_h < H_SYNC_END);
        b_vs = (t_v >= V_SYNC_START) && (t_v < V_SYNC_END);
        b_rgb = border_color(t_h, t_v);

        // Next pixel
        if (t_h == H_TOTAL - 11'd1) begin
          t_h = '0;
          t_v = (t_v == V_TOTAL - 11'd1) ? '0 : t_v + 11'd1;
        end else begin
          t_h = t_h + 11'd1;
        end
        cyc = cyc + 1;
        if (cyc == 2) begin
          report_test(3'd1, "reset");
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    int hold_cnt;
    int prop_fails;
    pclk = 1'b0;
    rst  <= 1'b1;
    xpos <= '0;
    ypos <= '0;
    hold_cnt = 0;
    void'($urandom(32'h9f39bcba));
    repeat (3) @(posedge pclk);
    rst <= 1'b0;

    // New corner every 1..5000 cycles, full visible range so edges clip
    repeat (RUN_CYCLES) begin
      @(posedge pclk);
      if (hold_cnt == 0) begin
        xpos <= CNT_W'($urandom_range(32'(H_ACTIVE) - 1, 0));
        ypos <= CNT_W'($urandom_range(32'(V_ACTIVE) - 1, 0));
        hold_cnt = $urandom_range(5000, 1) - 1;
      end else begin
        hold_cnt = hold_cnt - 1;
      end
    end

    report_test(3'd2, "sync timing");
    report_test(3'd3, "background");
    report_test(3'd4, "rectangle overlay");
    report_test(3'd5, "per-frame capture");
    if (n_chk[4] == 0 || n_chk[5] == 0) begin
      $display("Rectangle or capture pixels were never exercised");
      total_err = total_err + 1;
    end
    prop_fails = uut.u_vga_timing.u_vga_props.fail_cnt;
    $display("checks %0d, errors %0d, assertion failures %0d",
             total_chk, total_err, prop_fails);
    if (total_err == 0 && prop_fails == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* verilog.f */
vga_pkg.sv
vga_timing.sv
draw_background.sv
draw_rect.sv
vga_top.sv
vga_props.sv
vga_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= vga_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
